//--- list.f
+incdir+sim
rtl/cpuPkg.sv
rtl/laneBuses.sv
rtl/fetchSplitter.sv
rtl/instDecoder.sv
rtl/dispatchPacker.sv
rtl/decodeStage.sv
sim/tbDecodeStage.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run the testbench and scan the log for the fail message.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
(verilator --binary --timing -Wno-fatal -f list.f --top-module tbDecodeStage -Mdir obj_dir &&
    ./obj_dir/VtbDecodeStage) > sim.log 2>&1 || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

//--- sim/decodeModel.svh
`ifndef decodeModelSvh
`define decodeModelSvh

// one expected dispatch group whose slots past count stay zero.
typedef struct packed {
    logic [31:0]                             dueCycle; // zero when latency is not checked.
    logic [CountW-1:0]                       count;
    cpuPkg::opType [Lanes-1:0]               op;
    logic [Lanes-1:0][cpuPkg::NameWidth-1:0] rd;
    logic [Lanes-1:0][cpuPkg::NameWidth-1:0] rs1;
    logic [Lanes-1:0][cpuPkg::NameWidth-1:0] rs2;
    logic [Lanes-1:0][cpuPkg::ImmWidth-1:0]  imm;
    logic [Lanes-1:0][cpuPkg::AddrWidth-1:0] pc;
    logic [Lanes-1:0][cpuPkg::AddrWidth-1:0] target;
    logic [Lanes-1:0]                        pd;
    logic [Lanes-1:0][TagW-1:0]              tag;
} expPkt;

// funct3 tables taken from the RV32I opcode map.
localparam cpuPkg::opType BranchOps [8] = '{cpuPkg::BEQ, cpuPkg::BNE, cpuPkg::NOP, cpuPkg::NOP,
                                            cpuPkg::BLT, cpuPkg::BGE, cpuPkg::BLTU, cpuPkg::BGEU};
localparam cpuPkg::opType LoadOps [8] = '{cpuPkg::LB, cpuPkg::LH, cpuPkg::LW, cpuPkg::NOP,
                                          cpuPkg::LBU, cpuPkg::LHU, cpuPkg::NOP, cpuPkg::NOP};
localparam cpuPkg::opType StoreOps [8] = '{cpuPkg::SB, cpuPkg::SH, cpuPkg::SW, cpuPkg::NOP,
                                           cpuPkg::NOP, cpuPkg::NOP, cpuPkg::NOP, cpuPkg::NOP};
localparam cpuPkg::opType ImmOps [8] = '{cpuPkg::ADDI, cpuPkg::SLLI, cpuPkg::SLTI, cpuPkg::SLTIU,
                                         cpuPkg::XORI, cpuPkg::SRLI, cpuPkg::ORI, cpuPkg::ANDI};
localparam cpuPkg::opType RegOps [8] = '{cpuPkg::ADD, cpuPkg::SLL, cpuPkg::SLT, cpuPkg::SLTU,
                                         cpuPkg::XOR, cpuPkg::SRL, cpuPkg::OR, cpuPkg::AND};

function automatic cpuPkg::opType refOp(input logic [31:0] inst);
    logic [2:0] f3;
    f3 = inst[14:12];
    case (inst[6:0])
        cpuPkg::MAJ_LUI:    return cpuPkg::LUI;
        cpuPkg::MAJ_AUIPC:  return cpuPkg::AUIPC;
        cpuPkg::MAJ_JAL:    return cpuPkg::JAL;
        cpuPkg::MAJ_JALR:   return cpuPkg::JALR;
        cpuPkg::MAJ_BRANCH: return BranchOps[f3];
        cpuPkg::MAJ_LOAD:   return LoadOps[f3];
        cpuPkg::MAJ_STORE:  return StoreOps[f3];
        cpuPkg::MAJ_OPIMM:  return (f3 == 3'b101 && inst[30]) ? cpuPkg::SRAI : ImmOps[f3];
        cpuPkg::MAJ_OP: begin
            if (inst[30] && f3 == 3'b000) return cpuPkg::SUB;
            if (inst[30] && f3 == 3'b101) return cpuPkg::SRA;
            return RegOps[f3];
        end
        default: return cpuPkg::NOP;
    endcase
endfunction

function automatic logic [31:0] refImm(input logic [31:0] inst);
    case (inst[6:0])
        cpuPkg::MAJ_LUI, cpuPkg::MAJ_AUIPC:
            return {inst[31:12], 12'h000};
        cpuPkg::MAJ_JAL:
            return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        cpuPkg::MAJ_BRANCH:
            return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        cpuPkg::MAJ_JALR, cpuPkg::MAJ_LOAD, cpuPkg::MAJ_OPIMM:
            return {{20{inst[31]}}, inst[31:20]};
        cpuPkg::MAJ_STORE:
            return {{20{inst[31]}}, inst[31:25], inst[11:7]};
        default:
            return 32'h0;
    endcase
endfunction

function automatic logic isRelative(input cpuPkg::opType op);
    return op inside {cpuPkg::JAL, cpuPkg::BEQ, cpuPkg::BNE, cpuPkg::BLT,
                      cpuPkg::BGE, cpuPkg::BLTU, cpuPkg::BGEU};
endfunction

function automatic expPkt modelPacket(
    input logic [Lanes-1:0][cpuPkg::InstWidth-1:0] insts,
    input logic [cpuPkg::AddrWidth-1:0]            basePc,
    input logic [Lanes-1:0]                        mask,
    input logic [Lanes-1:0]                        pdIn,
    input logic [TagW-1:0]                         base
);
    expPkt       p;
    int          k;
    logic        ended;
    logic [31:0] lanePc;
    p = '0;
    k = 0;
    ended = 1'b0;
    for (int i = 0; i < Lanes; i++) begin
        if (mask[i] && !ended) begin
            lanePc      = basePc + 32'(4 * i);
            p.op[k]     = refOp(insts[i]);
            p.rd[k]     = insts[i][11:7];
            p.rs1[k]    = insts[i][19:15];
            p.rs2[k]    = insts[i][24:20];
            p.imm[k]    = refImm(insts[i]);
            p.pc[k]     = lanePc;
            p.target[k] = lanePc + (isRelative(p.op[k]) ? p.imm[k] : 32'd4);
            p.pd[k]     = pdIn[i];
            p.tag[k]    = base + TagW'(k);
            ended       = pdIn[i]; // a taken prediction ends the packet.
            k++;
        end
    end
    p.count = CountW'(k);
    return p;
endfunction

// legal encodings of each major opcode, plus raw words that are mostly unknown.
function automatic logic [31:0] randInst();
    logic [31:0] w;
    int          kind;
    w = $urandom;
    kind = $urandom_range(9, 0);
    case (kind)
        0: w[6:0] = cpuPkg::MAJ_LUI;
        1: w[6:0] = cpuPkg::MAJ_AUIPC;
        2: w[6:0] = cpuPkg::MAJ_JAL;
        3: begin
            w[6:0]   = cpuPkg::MAJ_JALR;
            w[14:12] = 3'b000;
        end
        4: w[6:0] = cpuPkg::MAJ_BRANCH;
        5: w[6:0] = cpuPkg::MAJ_LOAD;
        6: w[6:0] = cpuPkg::MAJ_STORE;
        7: begin
            w[6:0] = cpuPkg::MAJ_OPIMM;
            if (w[13:12] == 2'b01) begin
                w[31:25] = {1'b0, w[30], 5'b0}; // shifts keep a clean funct7.
            end
        end
        8: begin
            w[6:0]   = cpuPkg::MAJ_OP;
            w[31:25] = {1'b0, w[30], 5'b0};
        end
        default: w = w;
    endcase
    return w;
endfunction

`endif

//--- sim/tbDecodeStage.sv
`timescale 1ns/100ps

module tbDecodeStage;

    localparam int Lanes  = cpuPkg::DefLanes;
    localparam int TagW   = cpuPkg::DefTagWidth;
    localparam int CountW = $clog2(Lanes + 1);

    localparam int ResetCycles  = 10;
    localparam int ResetChecks  = 8;
    localparam int FullPackets  = 40;
    localparam int MaskPackets  = 60;
    localparam int TagPackets   = 200;
    localparam int StallPackets = 150;
    localparam int DrainCycles  = 4;
    localparam int TestCycles   = ResetCycles + ResetChecks + FullPackets + MaskPackets
                                  + TagPackets + StallPackets + 4 * DrainCycles;

    `include "decodeModel.svh"

    logic                                    clk;
    logic                                    rst;
    logic                                    rdy;
    logic                                    fetchEn;
    logic [Lanes-1:0][cpuPkg::InstWidth-1:0] fetchInst;
    logic [cpuPkg::AddrWidth-1:0]            fetchPc;
    logic [Lanes-1:0]                        fetchMask;
    logic [Lanes-1:0]                        fetchPd;
    logic                                    dispValid;
    logic [CountW-1:0]                       dispCount;
    cpuPkg::opType [Lanes-1:0]               dispOp;
    logic [Lanes-1:0][cpuPkg::NameWidth-1:0] dispRd;
    logic [Lanes-1:0][cpuPkg::NameWidth-1:0] dispRs1;
    logic [Lanes-1:0][cpuPkg::NameWidth-1:0] dispRs2;
    logic [Lanes-1:0][cpuPkg::ImmWidth-1:0]  dispImm;
    logic [Lanes-1:0][cpuPkg::AddrWidth-1:0] dispPc;
    logic [Lanes-1:0][cpuPkg::AddrWidth-1:0] dispTarget;
    logic [Lanes-1:0]                        dispPd;
    logic [Lanes-1:0][TagW-1:0]              dispTag;

    expPkt           expQ [$];
    logic [TagW-1:0] tagBase = '0;
    int              cycle = 0;
    logic            rdyAtEdge = 1'b0;
    int              errors = 0;
    int              errStart = 0;
    int              okCount = 0;
    int              failCount = 0;
    string           curTest = "none";

    decodeStage u_decodeStage (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle     <= cycle + 1;
        rdyAtEdge <= rdy;
    end

    task automatic compareField(input string field, input int slot, input logic [31:0] exp,
                                input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAILED %s %s slot %0d: expected %h, actual %h", curTest, field, slot,
                     exp, act);
        end
    endtask

    always @(negedge clk) begin
        expPkt e;
        if (!rst && dispValid) begin
            if (!rdyAtEdge) begin
                errors++;
                $display("%s: dispatch pulse after an edge with rdy low", curTest);
            end
            if (expQ.size() == 0) begin
                errors++;
                $display("%s: dispatch seen with no packet expected", curTest);
            end else begin
                e = expQ.pop_front();
                if (e.dueCycle != 0) begin
                    compareField("cycle", 0, e.dueCycle, cycle);
                end
                compareField("count", 0, 32'(e.count), 32'(dispCount));
                for (int k = 0; k < Lanes; k++) begin
                    compareField("op", k, 32'(e.op[k]), 32'(dispOp[k]));
                    compareField("rd", k, 32'(e.rd[k]), 32'(dispRd[k]));
                    compareField("rs1", k, 32'(e.rs1[k]), 32'(dispRs1[k]));
                    compareField("rs2", k, 32'(e.rs2[k]), 32'(dispRs2[k]));
                    compareField("imm", k, e.imm[k], dispImm[k]);
                    compareField("pc", k, e.pc[k], dispPc[k]);
                    compareField("target", k, e.target[k], dispTarget[k]);
                    compareField("pd", k, 32'(e.pd[k]), 32'(dispPd[k]));
                    compareField("tag", k, 32'(e.tag[k]), 32'(dispTag[k]));
                end
            end
        end
    end

    task automatic drivePacket(input bit en, input bit r, input bit randMask, input bit timed);
        expPkt p;
        @(posedge clk);
        #1;
        for (int i = 0; i < Lanes; i++) begin
            fetchInst[i] = randInst();
        end
        fetchPc   = $urandom & ~32'h3;
        fetchMask = randMask ? Lanes'($urandom) : {Lanes{1'b1}};
        fetchPd   = randMask ? Lanes'($urandom & $urandom) : '0;
        fetchEn   = en;
        rdy       = r;
        if (en && r) begin
            p = modelPacket(fetchInst, fetchPc, fetchMask, fetchPd, tagBase);
            if (p.count != 0) begin
                p.dueCycle = timed ? 32'(cycle + 2) : 32'h0; // two cycles after it is presented.
                expQ.push_back(p);
                tagBase = tagBase + TagW'(p.count);
            end
        end
    endtask

    task automatic idleCycle();
        @(posedge clk);
        #1;
        rdy     = 1'b1;
        fetchEn = 1'b0;
    endtask

    task automatic drainPipe();
        repeat (DrainCycles) idleCycle();
        if (expQ.size() != 0) begin
            errors++;
            $display("%s: %0d packets were never dispatched", curTest, expQ.size());
            expQ.delete();
        end
    endtask

    task automatic startTest(input string name);
        curTest  = name;
        errStart = errors;
    endtask

    task automatic finishTest();
        if (errors == errStart) begin
            okCount++;
            $display("%s: ok", curTest);
        end else begin
            failCount++;
            $display("%s: %0d errors", curTest, errors - errStart);
        end
    endtask

    initial begin
        #(TestCycles * 8 * 3);
        $display("timeout: the run did not finish in the expected time");
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h96375e75));
        rst       = 1'b1;
        rdy       = 1'b0;
        fetchEn   = 1'b0;
        fetchInst = '0;
        fetchPc   = '0;
        fetchMask = '0;
        fetchPd   = '0;
        repeat (ResetCycles) @(posedge clk);
        #1;
        rst = 1'b0;

        startTest("reset");
        repeat (ResetChecks) begin
            idleCycle();
            @(negedge clk);
            compareField("dispValid", 0, 32'h0, 32'(dispValid));
            compareField("dispCount", 0, 32'h0, 32'(dispCount));
        end
        finishTest();

        startTest("fullDecode");
        repeat (FullPackets) drivePacket(1'b1, 1'b1, 1'b0, 1'b1);
        drainPipe();
        finishTest();

        startTest("maskCompaction");
        repeat (MaskPackets) drivePacket(1'b1, 1'b1, 1'b1, 1'b1);
        drainPipe();
        finishTest();

        startTest("tagWrap");
        repeat (TagPackets) drivePacket(1'b1, 1'b1, 1'b1, 1'b1);
        drainPipe();
        finishTest();

        startTest("stall");
        repeat (StallPackets) begin
            drivePacket($urandom_range(3, 0) != 0, $urandom_range(2, 0) != 0, 1'b1, 1'b0);
        end
        drainPipe();
        finishTest();

        $display("summary: %0d tests ok, %0d tests with errors", okCount, failCount);
        if (failCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- rtl/decodeStage.sv
`timescale 1ns/100ps

module decodeStage #(
    parameter int Lanes    = cpuPkg::DefLanes,
    parameter int TagWidth = cpuPkg::DefTagWidth
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    rdy,
    input  logic                                    fetchEn,
    input  logic [Lanes-1:0][cpuPkg::InstWidth-1:0] fetchInst,
    input  logic [cpuPkg::AddrWidth-1:0]            fetchPc,
    input  logic [Lanes-1:0]                        fetchMask,
    input  logic [Lanes-1:0]                        fetchPd,
    output logic                                    dispValid,
    output logic [$clog2(Lanes+1)-1:0]              dispCount,
    output cpuPkg::opType [Lanes-1:0]               dispOp,
    output logic [Lanes-1:0][cpuPkg::NameWidth-1:0] dispRd,
    output logic [Lanes-1:0][cpuPkg::NameWidth-1:0] dispRs1,
    output logic [Lanes-1:0][cpuPkg::NameWidth-1:0] dispRs2,
    output logic [Lanes-1:0][cpuPkg::ImmWidth-1:0]  dispImm,
    output logic [Lanes-1:0][cpuPkg::AddrWidth-1:0] dispPc,
    output logic [Lanes-1:0][cpuPkg::AddrWidth-1:0] dispTarget,
    output logic [Lanes-1:0]                        dispPd,
    output logic [Lanes-1:0][TagWidth-1:0]          dispTag
);

    laneBus   lanes   [Lanes] ();
    decodeBus decoded [Lanes] ();

    fetchSplitter #(
        .Lanes(Lanes)
    ) u_fetchSplitter (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .fetchEn  (fetchEn),
        .fetchInst(fetchInst),
        .fetchPc  (fetchPc),
        .fetchMask(fetchMask),
        .fetchPd  (fetchPd),
        .lanes    (lanes)
    );

    // every lane decodes in parallel between the two registers.
    for (genvar i = 0; i < Lanes; i++) begin : decodeGen
        instDecoder u_instDecoder (
            .lane(lanes[i]),
            .dec (decoded[i])
        );
    end

    dispatchPacker #(
        .Lanes   (Lanes),
        .TagWidth(TagWidth)
    ) u_dispatchPacker (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .dec       (decoded),
        .dispValid (dispValid),
        .dispCount (dispCount),
        .dispOp    (dispOp),
        .dispRd    (dispRd),
        .dispRs1   (dispRs1),
        .dispRs2   (dispRs2),
        .dispImm   (dispImm),
        .dispPc    (dispPc),
        .dispTarget(dispTarget),
        .dispPd    (dispPd),
        .dispTag   (dispTag)
    );

endmodule

//--- rtl/dispatchPacker.sv
`timescale 1ns/100ps

module dispatchPacker #(
    parameter int Lanes    = cpuPkg::DefLanes,
    parameter int TagWidth = cpuPkg::DefTagWidth
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    rdy,
    decodeBus.dst                                   dec [Lanes],
    output logic                                    dispValid,
    output logic [$clog2(Lanes+1)-1:0]              dispCount,
    output cpuPkg::opType [Lanes-1:0]               dispOp,
    output logic [Lanes-1:0][cpuPkg::NameWidth-1:0] dispRd,
    output logic [Lanes-1:0][cpuPkg::NameWidth-1:0] dispRs1,
    output logic [Lanes-1:0][cpuPkg::NameWidth-1:0] dispRs2,
    output logic [Lanes-1:0][cpuPkg::ImmWidth-1:0]  dispImm,
    output logic [Lanes-1:0][cpuPkg::AddrWidth-1:0] dispPc,
    output logic [Lanes-1:0][cpuPkg::AddrWidth-1:0] dispTarget,
    output logic [Lanes-1:0]                        dispPd,
    output logic [Lanes-1:0][TagWidth-1:0]          dispTag
);

    localparam int CountWidth = $clog2(Lanes + 1);
    localparam int SlotWidth  = (Lanes > 1) ? $clog2(Lanes) : 1;

    logic [Lanes-1:0]                        laneValid;
    cpuPkg::opType [Lanes-1:0]               laneOp;
    logic [Lanes-1:0][cpuPkg::NameWidth-1:0] laneRd;
    logic [Lanes-1:0][cpuPkg::NameWidth-1:0] laneRs1;
    logic [Lanes-1:0][cpuPkg::NameWidth-1:0] laneRs2;
    logic [Lanes-1:0][cpuPkg::ImmWidth-1:0]  laneImm;
    logic [Lanes-1:0][cpuPkg::AddrWidth-1:0] lanePc;
    logic [Lanes-1:0][cpuPkg::AddrWidth-1:0] laneTarget;
    logic [Lanes-1:0]                        lanePd;

    cpuPkg::opType [Lanes-1:0]               packOp;
    logic [Lanes-1:0][cpuPkg::NameWidth-1:0] packRd;
    logic [Lanes-1:0][cpuPkg::NameWidth-1:0] packRs1;
    logic [Lanes-1:0][cpuPkg::NameWidth-1:0] packRs2;
    logic [Lanes-1:0][cpuPkg::ImmWidth-1:0]  packImm;
    logic [Lanes-1:0][cpuPkg::AddrWidth-1:0] packPc;
    logic [Lanes-1:0][cpuPkg::AddrWidth-1:0] packTarget;
    logic [Lanes-1:0]                        packPd;
    logic [Lanes-1:0][TagWidth-1:0]          packTag;
    logic [CountWidth-1:0]                   packCount;
    logic [SlotWidth-1:0]                    slot;
    logic [TagWidth-1:0]                     tagBase;

    for (genvar i = 0; i < Lanes; i++) begin : laneGen
        logic relTarget;
        assign relTarget = dec[i].op inside {cpuPkg::JAL, cpuPkg::BEQ, cpuPkg::BNE,
                                             cpuPkg::BLT, cpuPkg::BGE, cpuPkg::BLTU,
                                             cpuPkg::BGEU};
        assign laneValid[i]  = dec[i].valid;
        assign laneOp[i]     = dec[i].op;
        assign laneRd[i]     = dec[i].rd;
        assign laneRs1[i]    = dec[i].rs1;
        assign laneRs2[i]    = dec[i].rs2;
        assign laneImm[i]    = dec[i].imm;
        assign lanePc[i]     = dec[i].pc;
        assign lanePd[i]     = dec[i].pd;
        // jalr depends on a register, so it falls through like any other op.
        assign laneTarget[i] = dec[i].pc + (relTarget ? cpuPkg::AddrWidth'(dec[i].imm)
                                                      : cpuPkg::AddrWidth'(4));
    end

    always_comb begin
        packOp     = '0;
        packRd     = '0;
        packRs1    = '0;
        packRs2    = '0;
        packImm    = '0;
        packPc     = '0;
        packTarget = '0;
        packPd     = '0;
        packTag    = '0;
        packCount  = '0;
        slot       = '0;
        for (int i = 0; i < Lanes; i++) begin
            if (laneValid[i]) begin
                slot             = SlotWidth'(packCount);
                packOp[slot]     = laneOp[i];
                packRd[slot]     = laneRd[i];
                packRs1[slot]    = laneRs1[i];
                packRs2[slot]    = laneRs2[i];
                packImm[slot]    = laneImm[i];
                packPc[slot]     = lanePc[i];
                packTarget[slot] = laneTarget[i];
                packPd[slot]     = lanePd[i];
                packTag[slot]    = tagBase + TagWidth'(packCount); // wraps with the rob.
                packCount        = packCount + CountWidth'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dispValid <= 1'b0;
            dispCount <= '0;
            tagBase   <= '0;
        end else if (rdy) begin
            dispValid <= packCount != '0;
            dispCount <= packCount;
            tagBase   <= tagBase + TagWidth'(packCount);
        end else begin
            dispValid <= 1'b0; // a held packet is announced only once.
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            dispOp     <= packOp;
            dispRd     <= packRd;
            dispRs1    <= packRs1;
            dispRs2    <= packRs2;
            dispImm    <= packImm;
            dispPc     <= packPc;
            dispTarget <= packTarget;
            dispPd     <= packPd;
            dispTag    <= packTag;
        end
    end

endmodule

//--- rtl/instDecoder.sv
`timescale 1ns/100ps

module instDecoder (
    laneBus.dst   lane,
    decodeBus.src dec
);

    logic [cpuPkg::InstWidth-1:0] inst;
    logic [6:0]                   opcode;
    logic [2:0]                   funct3;
    logic                         alt;
    cpuPkg::opType                op;
    logic [cpuPkg::ImmWidth-1:0]  imm;

    assign inst   = lane.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign alt    = inst[30]; // selects sub and arithmetic shifts.

    assign dec.valid = lane.valid;
    assign dec.pc    = lane.pc;
    assign dec.pd    = lane.pd;
    assign dec.rd    = inst[11:7];
    assign dec.rs1   = inst[19:15];
    assign dec.rs2   = inst[24:20];
    assign dec.op    = op;
    assign dec.imm   = imm;

    always_comb begin
        case (opcode)
            cpuPkg::MAJ_LUI,
            cpuPkg::MAJ_AUIPC: begin
                imm = {inst[31:12], 12'b0};
            end
            cpuPkg::MAJ_JAL: begin
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            cpuPkg::MAJ_BRANCH: begin
                imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            cpuPkg::MAJ_JALR,
            cpuPkg::MAJ_OPIMM,
            cpuPkg::MAJ_LOAD: begin
                imm = {{21{inst[31]}}, inst[30:20]};
            end
            cpuPkg::MAJ_STORE: begin
                imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            end
            default: begin
                imm = '0; // register ops and unknown words carry no immediate.
            end
        endcase
    end

    always_comb begin
        op = cpuPkg::NOP;
        case (opcode)
            cpuPkg::MAJ_LUI:   op = cpuPkg::LUI;
            cpuPkg::MAJ_AUIPC: op = cpuPkg::AUIPC;
            cpuPkg::MAJ_JAL:   op = cpuPkg::JAL;
            cpuPkg::MAJ_JALR:  op = cpuPkg::JALR;
            cpuPkg::MAJ_BRANCH: begin
                case (funct3)
                    3'b000:  op = cpuPkg::BEQ;
                    3'b001:  op = cpuPkg::BNE;
                    3'b100:  op = cpuPkg::BLT;
                    3'b101:  op = cpuPkg::BGE;
                    3'b110:  op = cpuPkg::BLTU;
                    3'b111:  op = cpuPkg::BGEU;
                    default: op = cpuPkg::NOP;
                endcase
            end
            cpuPkg::MAJ_LOAD: begin
                case (funct3)
                    3'b000:  op = cpuPkg::LB;
                    3'b001:  op = cpuPkg::LH;
                    3'b010:  op = cpuPkg::LW;
                    3'b100:  op = cpuPkg::LBU;
                    3'b101:  op = cpuPkg::LHU;
                    default: op = cpuPkg::NOP;
                endcase
            end
            cpuPkg::MAJ_STORE: begin
                case (funct3)
                    3'b000:  op = cpuPkg::SB;
                    3'b001:  op = cpuPkg::SH;
                    3'b010:  op = cpuPkg::SW;
                    default: op = cpuPkg::NOP;
                endcase
            end
            cpuPkg::MAJ_OPIMM: begin
                case (funct3)
                    3'b000: op = cpuPkg::ADDI; // there is no subtract immediate.
                    3'b001: op = cpuPkg::SLLI;
                    3'b010: op = cpuPkg::SLTI;
                    3'b011: op = cpuPkg::SLTIU;
                    3'b100: op = cpuPkg::XORI;
                    3'b101: op = alt ? cpuPkg::SRAI : cpuPkg::SRLI;
                    3'b110: op = cpuPkg::ORI;
                    3'b111: op = cpuPkg::ANDI;
                endcase
            end
            cpuPkg::MAJ_OP: begin
                case (funct3)
                    3'b000: op = alt ? cpuPkg::SUB : cpuPkg::ADD;
                    3'b001: op = cpuPkg::SLL;
                    3'b010: op = cpuPkg::SLT;
                    3'b011: op = cpuPkg::SLTU;
                    3'b100: op = cpuPkg::XOR;
                    3'b101: op = alt ? cpuPkg::SRA : cpuPkg::SRL;
                    3'b110: op = cpuPkg::OR;
                    3'b111: op = cpuPkg::AND;
                endcase
            end
            default: op = cpuPkg::NOP;
        endcase
    end

endmodule

//--- rtl/fetchSplitter.sv
`timescale 1ns/100ps

module fetchSplitter #(
    parameter int Lanes = cpuPkg::DefLanes
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    rdy,
    input  logic                                    fetchEn,
    input  logic [Lanes-1:0][cpuPkg::InstWidth-1:0] fetchInst,
    input  logic [cpuPkg::AddrWidth-1:0]            fetchPc,
    input  logic [Lanes-1:0]                        fetchMask,
    input  logic [Lanes-1:0]                        fetchPd,
    laneBus.src                                     lanes [Lanes]
);

    logic [Lanes-1:0]                        keep;
    logic                                    taken;
    logic [Lanes-1:0]                        validQ;
    logic [Lanes-1:0][cpuPkg::InstWidth-1:0] instQ;
    logic [cpuPkg::AddrWidth-1:0]            pcQ;
    logic [Lanes-1:0]                        pdQ;

    // the first surviving lane that is predicted taken closes the packet.
    always_comb begin
        taken = 1'b0;
        for (int i = 0; i < Lanes; i++) begin
            keep[i] = fetchEn & fetchMask[i] & ~taken;
            taken   = taken | (keep[i] & fetchPd[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validQ <= '0;
        end else if (rdy) begin
            validQ <= keep; // an idle cycle loads an empty packet.
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            instQ <= fetchInst;
            pcQ   <= fetchPc;
            pdQ   <= fetchPd;
        end
    end

    for (genvar i = 0; i < Lanes; i++) begin : laneGen
        assign lanes[i].valid = validQ[i];
        assign lanes[i].inst  = instQ[i];
        assign lanes[i].pc    = pcQ + (cpuPkg::AddrWidth'(i) << 2); // one word per lane.
        assign lanes[i].pd    = pdQ[i];
    end

endmodule

//--- rtl/laneBuses.sv
`timescale 1ns/100ps

interface laneBus;
    logic                         valid;
    logic [cpuPkg::InstWidth-1:0] inst;
    logic [cpuPkg::AddrWidth-1:0] pc;
    logic                         pd; // predicted taken by fetch.

    modport src (
        output valid, inst, pc, pd
    );

    modport dst (
        input valid, inst, pc, pd
    );
endinterface

interface decodeBus;
    logic                         valid;
    cpuPkg::opType                op;
    logic [cpuPkg::NameWidth-1:0] rd;
    logic [cpuPkg::NameWidth-1:0] rs1;
    logic [cpuPkg::NameWidth-1:0] rs2;
    logic [cpuPkg::ImmWidth-1:0]  imm;
    logic [cpuPkg::AddrWidth-1:0] pc;
    logic                         pd;

    modport src (
        output valid, op, rd, rs1, rs2, imm, pc, pd
    );

    modport dst (
        input valid, op, rd, rs1, rs2, imm, pc, pd
    );
endinterface

//--- rtl/cpuPkg.sv
package cpuPkg;

    parameter int InstWidth = 32;
    parameter int AddrWidth = 32;
    parameter int NameWidth = 5;
    parameter int ImmWidth  = 32;

    parameter int DefLanes    = 4;
    parameter int DefTagWidth = 4;

    // NOP must stay at zero so that empty dispatch slots read as all zeros.
    typedef enum logic [5:0] {
        NOP,
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW,
        ADDI,
        SLTI,
        SLTIU,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } opType;

    typedef enum logic [6:0] {
        MAJ_LOAD   = 7'b0000011,
        MAJ_STORE  = 7'b0100011,
        MAJ_BRANCH = 7'b1100011,
        MAJ_JAL    = 7'b1101111,
        MAJ_JALR   = 7'b1100111,
        MAJ_OPIMM  = 7'b0010011,
        MAJ_OP     = 7'b0110011,
        MAJ_LUI    = 7'b0110111,
        MAJ_AUIPC  = 7'b0010111
    } majorOp;

endpackage
